// File: logic/eth_tx_pkg.sv
package eth_tx_pkg;

	// ------------------------------------------------------------------
	// ring geometry
	// ------------------------------------------------------------------
	localparam int BUFFER_SLOTS     = 4;
	localparam int SLOT_BITS        = 2;
	localparam int MAX_PACKET_BYTES = 64;
	localparam int LEN_BITS         = 7;   // byte address and length

	// ------------------------------------------------------------------
	// frame layout
	// ------------------------------------------------------------------
	localparam int          PREAMBLE_BYTES  = 7;
	localparam logic [7:0]  PREAMBLE_BYTE   = 8'h55;
	localparam logic [7:0]  SFD_BYTE        = 8'hd5;
	localparam int          INTERGAP_CYCLES = 12;
	localparam logic [31:0] CRC_POLY        = 32'h04c1_1db7;   // 802.3, msb-first form

	typedef enum logic [1:0] {
		OP_WRITE      = 2'd0,   // store one byte in the open slot
		OP_WRITE_LEN  = 2'd1,   // read back the open slot length
		OP_WRITE_NEXT = 2'd2    // commit the open slot
	} tx_op_t;

	typedef enum logic [2:0] {
		IDLE,
		PREAMBLE,
		SFD,
		DATA,
		FCS,
		INTERGAP
	} framer_state_t;

	typedef struct packed {
		tx_op_t              op;
		logic [LEN_BITS-1:0] address;
		logic [7:0]          value;
	} host_cmd_t;

	typedef struct packed {
		logic                valid;    // oldest committed slot waiting or in flight
		logic [LEN_BITS-1:0] length;
	} head_slot_t;

	typedef struct packed {
		logic [LEN_BITS-1:0] addr;
		logic                rd;
		logic                retire;   // frees the head slot
	} head_read_t;

	typedef struct packed {
		logic [7:0] txd;
		logic       tx_en;
		logic       tx_er;
	} gmii_tx_t;

endpackage

// File: logic/crc32_accum.sv
`timescale 1ns/1ps

module crc32_accum (
	input  logic        clock,
	input  logic        reset,
	input  logic        clear,
	input  logic        enable,
	input  logic [7:0]  data_byte,
	output logic [31:0] crc
);

	logic [31:0] crc_q;
	logic [31:0] crc_next;

	// ------------------------------------------------------------------
	// byte-wide update of the 802.3 polynomial
	// ------------------------------------------------------------------
	// data bit 0 is the first bit on the wire, so the loop walks the byte
	// from bit 0 upward; it unrolls into the usual 32 xor equations
	function automatic logic [31:0] crc_byte_step(
		input logic [31:0] c,
		input logic [7:0]  d
	);
		logic [31:0] r;
		logic        fb;
		r = c;
		for (int i = 0; i < 8; i++) begin
			fb = r[31] ^ d[i];
			r  = {r[30:0], 1'b0} ^ (fb ? eth_tx_pkg::CRC_POLY : 32'h0);
		end
		return r;
	endfunction

	assign crc_next = crc_byte_step(crc_q, data_byte);

	always_ff @(posedge clock) begin
		if (reset) begin
			crc_q <= 32'hffff_ffff;
		end else if (clear) begin
			crc_q <= 32'hffff_ffff;   // 802.3 preset
		end else if (enable) begin
			crc_q <= crc_next;
		end
	end

	// the register's top byte holds the first FCS byte on the wire,
	// so the bytes are presented swapped and byte 0 goes out first
	assign crc = {crc_q[7:0], crc_q[15:8], crc_q[23:16], crc_q[31:24]};

endmodule

// File: logic/tx_packet_buffer.sv
`timescale 1ns/1ps

module tx_packet_buffer (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            start,
	input  eth_tx_pkg::host_cmd_t           cmd,
	output logic                            done,
	output logic [eth_tx_pkg::LEN_BITS-1:0] result,
	output eth_tx_pkg::head_slot_t          head,
	input  eth_tx_pkg::head_read_t          head_rd,
	output logic [7:0]                      head_byte
);

	logic [7:0] slot_mem [eth_tx_pkg::BUFFER_SLOTS][eth_tx_pkg::MAX_PACKET_BYTES];
	logic [eth_tx_pkg::LEN_BITS-1:0] slot_len [eth_tx_pkg::BUFFER_SLOTS];

	logic [eth_tx_pkg::SLOT_BITS-1:0] wr_ptr;        // open slot
	logic [eth_tx_pkg::SLOT_BITS-1:0] rd_ptr;        // head slot, oldest committed
	logic [eth_tx_pkg::SLOT_BITS-1:0] wr_ptr_next;

	logic addr_ok;
	logic ring_full;
	logic wr_en;
	logic commit;

	// ------------------------------------------------------------------
	// command decode
	// ------------------------------------------------------------------
	assign wr_ptr_next = wr_ptr + 1'b1;
	assign ring_full   = (wr_ptr_next == rd_ptr);   // one slot always kept open
	assign addr_ok     = (cmd.address < eth_tx_pkg::MAX_PACKET_BYTES);

	assign wr_en  = start && (cmd.op == eth_tx_pkg::OP_WRITE) && addr_ok;
	assign commit = start && (cmd.op == eth_tx_pkg::OP_WRITE_NEXT) && !ring_full
		&& (slot_len[wr_ptr] != '0);

	assign head.valid  = (wr_ptr != rd_ptr);
	assign head.length = slot_len[rd_ptr];

	// payload storage
	always_ff @(posedge clock) begin
		if (wr_en) begin
			slot_mem[wr_ptr][cmd.address[eth_tx_pkg::LEN_BITS-2:0]] <= cmd.value;
		end
	end

	// ------------------------------------------------------------------
	// pointers and lengths
	// ------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			done   <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			for (int i = 0; i < eth_tx_pkg::BUFFER_SLOTS; i++) begin
				slot_len[i] <= '0;
			end
		end else begin
			done <= start;   // every command answers next cycle

			if (head_rd.retire) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			if (wr_en && (cmd.address >= slot_len[wr_ptr])) begin
				slot_len[wr_ptr] <= cmd.address + 1'b1;   // grow to highest byte
			end

			if (commit) begin
				wr_ptr             <= wr_ptr_next;
				slot_len[wr_ptr_next] <= '0;   // fresh open slot
			end
		end
	end

	// host result
	always_ff @(posedge clock) begin
		if (start) begin
			case (cmd.op)
				eth_tx_pkg::OP_WRITE: begin
					result <= {{(eth_tx_pkg::LEN_BITS-1){1'b0}}, ~addr_ok};   // 1 = out of range
				end
				eth_tx_pkg::OP_WRITE_LEN: begin
					result <= slot_len[wr_ptr];
				end
				eth_tx_pkg::OP_WRITE_NEXT: begin
					result <= {{(eth_tx_pkg::LEN_BITS-1){1'b0}}, ring_full};   // 1 = overflow
				end
				default: begin
					result <= '0;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------
	// head slot read port, one cycle latency
	// ------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (head_rd.rd) begin
			if (head_rd.addr < head.length) begin
				head_byte <= slot_mem[rd_ptr][head_rd.addr[eth_tx_pkg::LEN_BITS-2:0]];
			end else begin
				head_byte <= 8'h00;   // past the end reads as zero
			end
		end
	end

endmodule

// File: logic/gmii_tx_framer.sv
`timescale 1ns/1ps

module gmii_tx_framer (
	input  logic                   clock,
	input  logic                   reset,
	input  eth_tx_pkg::head_slot_t head,
	output eth_tx_pkg::head_read_t head_rd,
	input  logic [7:0]             head_byte,
	output logic                   crc_clear,
	output logic                   crc_enable,
	output logic [7:0]             crc_data,
	input  logic [31:0]            crc,
	output eth_tx_pkg::gmii_tx_t   gmii
);

	eth_tx_pkg::framer_state_t state;

	logic [eth_tx_pkg::LEN_BITS-1:0] count;        // shared by every phase
	logic [eth_tx_pkg::LEN_BITS-1:0] count_next;
	logic [7:0]                      fcs_raw;
	logic [7:0]                      fcs_byte;

	assign count_next = count + 1'b1;

	// crc runs only over the payload
	assign crc_clear  = (state == eth_tx_pkg::IDLE);
	assign crc_enable = (state == eth_tx_pkg::DATA);
	assign crc_data   = head_byte;

	// fcs byte is the complemented, bit-reversed register byte
	always_comb begin
		fcs_raw = crc[8 * count[1:0] +: 8];
		for (int i = 0; i < 8; i++) begin
			fcs_byte[i] = ~fcs_raw[7 - i];
		end
	end

	// ------------------------------------------------------------------
	// slot read requests, one byte ahead of the wire
	// ------------------------------------------------------------------
	always_comb begin
		head_rd.addr   = '0;
		head_rd.rd     = 1'b0;
		head_rd.retire = 1'b0;
		case (state)
			eth_tx_pkg::SFD: begin
				head_rd.rd = 1'b1;   // byte 0 ready for the first data cycle
			end
			eth_tx_pkg::DATA: begin
				head_rd.rd   = 1'b1;
				head_rd.addr = count_next;
			end
			eth_tx_pkg::FCS: begin
				head_rd.retire = (count[1:0] == 2'd3);   // with the last fcs byte
			end
			default: begin
				head_rd.rd = 1'b0;
			end
		endcase
	end

	// ------------------------------------------------------------------
	// frame sequencer
	// ------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= eth_tx_pkg::IDLE;
			count <= '0;
			gmii  <= '0;
		end else begin
			gmii.tx_er <= 1'b0;
			gmii.tx_en <= 1'b1;
			case (state)
				eth_tx_pkg::IDLE: begin
					gmii.tx_en <= 1'b0;
					gmii.txd   <= 8'h00;
					count      <= '0;
					if (head.valid) begin
						state <= eth_tx_pkg::PREAMBLE;
					end
				end
				eth_tx_pkg::PREAMBLE: begin
					gmii.txd <= eth_tx_pkg::PREAMBLE_BYTE;
					count    <= count_next;
					if (count_next == eth_tx_pkg::PREAMBLE_BYTES) begin
						state <= eth_tx_pkg::SFD;
					end
				end
				eth_tx_pkg::SFD: begin
					gmii.txd <= eth_tx_pkg::SFD_BYTE;
					count    <= '0;
					state    <= eth_tx_pkg::DATA;
				end
				eth_tx_pkg::DATA: begin
					gmii.txd <= head_byte;   // prefetched last cycle
					count    <= count_next;
					if (count_next == head.length) begin
						count <= '0;
						state <= eth_tx_pkg::FCS;
					end
				end
				eth_tx_pkg::FCS: begin
					gmii.txd <= fcs_byte;
					count    <= count_next;
					if (count[1:0] == 2'd3) begin
						count <= '0;
						state <= eth_tx_pkg::INTERGAP;
					end
				end
				eth_tx_pkg::INTERGAP: begin
					gmii.tx_en <= 1'b0;
					gmii.txd   <= 8'h00;
					count      <= count_next;
					if (count_next == eth_tx_pkg::INTERGAP_CYCLES) begin
						state <= eth_tx_pkg::IDLE;
					end
				end
				default: begin
					gmii.tx_en <= 1'b0;
					state      <= eth_tx_pkg::IDLE;
				end
			endcase
		end
	end

endmodule

// File: logic/eth_tx_top.sv
`timescale 1ns/1ps

module eth_tx_top (
	input  logic                            clock,
	input  logic                            reset,
	input  logic                            start,
	input  eth_tx_pkg::host_cmd_t           cmd,
	output logic                            done,
	output logic [eth_tx_pkg::LEN_BITS-1:0] result,
	output eth_tx_pkg::gmii_tx_t            gmii
);

	eth_tx_pkg::head_slot_t head;
	eth_tx_pkg::head_read_t head_rd;
	logic [7:0]             head_byte;
	logic                   crc_clear;
	logic                   crc_enable;
	logic [7:0]             crc_data;
	logic [31:0]            crc;

	// ------------------------------------------------------------------
	// host side slot ring
	// ------------------------------------------------------------------
	tx_packet_buffer u_tx_packet_buffer (
		.clock     (clock),
		.reset     (reset),
		.start     (start),
		.cmd       (cmd),
		.done      (done),
		.result    (result),
		.head      (head),
		.head_rd   (head_rd),
		.head_byte (head_byte)
	);

	gmii_tx_framer u_gmii_tx_framer (
		.clock      (clock),
		.reset      (reset),
		.head       (head),
		.head_rd    (head_rd),
		.head_byte  (head_byte),
		.crc_clear  (crc_clear),
		.crc_enable (crc_enable),
		.crc_data   (crc_data),
		.crc        (crc),
		.gmii       (gmii)
	);

	crc32_accum u_crc32_accum (
		.clock     (clock),
		.reset     (reset),
		.clear     (crc_clear),
		.enable    (crc_enable),
		.data_byte (crc_data),
		.crc       (crc)
	);

endmodule

// File: tests/tb_eth_tx.sv
`timescale 1ns/1ps

module tb_eth_tx;

	logic                            clock = 1'b0;
	logic                            reset;
	logic                            start;
	eth_tx_pkg::host_cmd_t           cmd;
	logic                            done;
	logic [eth_tx_pkg::LEN_BITS-1:0] result;
	eth_tx_pkg::gmii_tx_t            gmii;

	integer     seed;
	int         errors      = 0;
	int         checks      = 0;
	int         test_base   = 0;
	int         frames_seen = 0;
	int         gap_cycles  = 0;
	logic       prev_en     = 1'b0;
	logic [7:0] frame_q[$];      // bytes of the frame on the wire
	logic [7:0] open_bytes[$];   // payload of the open slot
	logic [7:0] exp_bytes[$];    // committed payloads in commit order
	int         exp_lens[$];

	always #20 clock = ~clock;

	eth_tx_top u_eth_tx_top (
		.clock  (clock),
		.reset  (reset),
		.start  (start),
		.cmd    (cmd),
		.done   (done),
		.result (result),
		.gmii   (gmii)
	);

	task automatic expect_eq(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
		checks++;
		assert (act_v === exp_v) else begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp_v, act_v);
			errors++;
		end
	endtask

	// reflected 802.3 crc step taking one byte lsb first
	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c ^ {24'h0, d};
		for (int i = 0; i < 8; i++) begin
			r = r[0] ? ((r >> 1) ^ 32'hedb8_8320) : (r >> 1);
		end
		return r;
	endfunction

	task automatic check_frame();
		int          plen;
		logic [31:0] c;
		logic [7:0]  exp_b;
		logic [7:0]  act_b;
		if (exp_lens.size() == 0) begin
			$display("a frame was sent with no packet committed");
			errors++;
		end else begin
			plen = exp_lens.pop_front();
			c    = 32'hffff_ffff;
			expect_eq("frame length", plen + 12, frame_q.size());
			for (int i = 0; i < plen + 12; i++) begin
				if (i < eth_tx_pkg::PREAMBLE_BYTES) begin
					exp_b = eth_tx_pkg::PREAMBLE_BYTE;
				end else if (i == eth_tx_pkg::PREAMBLE_BYTES) begin
					exp_b = eth_tx_pkg::SFD_BYTE;
				end else if (i < plen + 8) begin
					exp_b = exp_bytes.pop_front();
					c     = crc_step(c, exp_b);
				end else begin
					exp_b = ~c[8 * (i - plen - 8) +: 8];   // fcs goes out low byte first
				end
				act_b = (i < frame_q.size()) ? frame_q[i] : 8'hxx;
				expect_eq("gmii.txd", exp_b, act_b);
			end
		end
		frame_q.delete();
	endtask

	// ----------------------------------------------------------------------
	// frame collector
	// ----------------------------------------------------------------------
	always @(negedge clock) begin
		if (!reset) begin
			assert (gmii.tx_er == 1'b0) else begin
				$display("CHECK FAILED gmii.tx_er expected %h actual %h", 1'b0, gmii.tx_er);
				errors++;
			end
			if (gmii.tx_en) begin
				if (!prev_en && frames_seen > 0) begin
					assert (gap_cycles >= eth_tx_pkg::INTERGAP_CYCLES) else begin
						$display("CHECK FAILED gap_cycles expected >= %h actual %h",
							eth_tx_pkg::INTERGAP_CYCLES, gap_cycles);
						errors++;
					end
				end
				frame_q.push_back(gmii.txd);
			end else begin
				if (prev_en) begin   // frame just ended
					check_frame();
					frames_seen++;
					gap_cycles = 0;
				end
				gap_cycles++;
			end
			prev_en = gmii.tx_en;
		end
	end

	// ----------------------------------------------------------------------
	// host command port
	// ----------------------------------------------------------------------
	task automatic run_cmd(input eth_tx_pkg::tx_op_t op, input int addr,
		input logic [7:0] value, output logic [6:0] res);
		int waited;
		waited = 0;
		@(posedge clock);
		start       <= 1'b1;
		cmd.op      <= op;
		cmd.address <= addr[6:0];
		cmd.value   <= value;
		@(negedge clock);
		expect_eq("done", 0, done);
		@(posedge clock);
		start <= 1'b0;
		do begin
			@(negedge clock);
			waited++;
		end while (!done && waited < 20);
		if (!done) begin
			$display("timeout: no done after a host command");
			errors++;
		end else begin
			expect_eq("done latency", 1, waited);
		end
		res = result;
	endtask

	task automatic fill_payload(input int len);
		logic [7:0] b;
		logic [6:0] res;
		for (int i = 0; i < len; i++) begin
			b = $random(seed);
			run_cmd(eth_tx_pkg::OP_WRITE, i, b, res);
			expect_eq("result", 0, res);
			open_bytes.push_back(b);
		end
	endtask

	task automatic commit_open(input logic [6:0] expected);
		logic [6:0] res;
		run_cmd(eth_tx_pkg::OP_WRITE_NEXT, 0, 8'h00, res);
		expect_eq("result", expected, res);
		if (expected == 0 && open_bytes.size() > 0) begin
			exp_lens.push_back(open_bytes.size());
			while (open_bytes.size() > 0) begin
				exp_bytes.push_back(open_bytes.pop_front());
			end
		end
	endtask

	task automatic wait_frames(input int target);
		int waited;
		waited = 0;
		while (frames_seen < target && waited < 500) begin
			@(posedge clock);
			waited++;
		end
		if (frames_seen < target) begin
			$display("timeout: frame %0d never finished", target);
			errors++;
		end
	endtask

	task automatic report_test(input int num, input string name);
		$display("test %0d %s: %s (%0d errors)", num, name,
			(errors == test_base) ? "ok" : "failed", errors - test_base);
		test_base = errors;
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial begin
		logic [6:0] res;
		logic       quiet;
		int         base;
		seed  = 32'h1d89ae91;
		reset = 1'b1;
		start = 1'b0;
		cmd   = '0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;

		@(negedge clock);
		expect_eq("done", 0, done);
		expect_eq("gmii.tx_en", 0, gmii.tx_en);
		expect_eq("gmii.tx_er", 0, gmii.tx_er);
		run_cmd(eth_tx_pkg::OP_WRITE_LEN, 0, 8'h00, res);
		expect_eq("result", 0, res);   // open slot starts empty
		report_test(1, "reset state and done latency");

		fill_payload(10);
		run_cmd(eth_tx_pkg::OP_WRITE_LEN, 0, 8'h00, res);
		expect_eq("result", 10, res);
		commit_open(0);
		wait_frames(1);
		report_test(2, "single frame");

		run_cmd(eth_tx_pkg::OP_WRITE, eth_tx_pkg::MAX_PACKET_BYTES, 8'ha5, res);
		expect_eq("result", 1, res);
		run_cmd(eth_tx_pkg::OP_WRITE_LEN, 0, 8'h00, res);
		expect_eq("result", 0, res);
		commit_open(0);   // empty slot sends nothing
		quiet = 1'b1;
		repeat (40) begin
			@(negedge clock);
			if (gmii.tx_en) begin
				quiet = 1'b0;
			end
		end
		assert (quiet) else begin
			$display("a frame started after committing an empty slot");
			errors++;
		end
		report_test(3, "out of range write and empty commit");

		base = frames_seen;
		fill_payload(20);
		commit_open(0);
		fill_payload(1);
		commit_open(0);
		fill_payload(1);
		commit_open(0);
		fill_payload(1);
		commit_open(1);   // three slots pending
		wait_frames(base + 1);
		commit_open(0);   // retry once the long frame has left
		report_test(4, "ring full and retry");

		wait_frames(base + 4);
		report_test(5, "frame order, payload and gap");

		$display("tests 5, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: all.f
logic/eth_tx_pkg.sv
logic/crc32_accum.sv
logic/tx_packet_buffer.sv
logic/gmii_tx_framer.sv
logic/eth_tx_top.sv
tests/tb_eth_tx.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -Wno-fatal --top-module tb_eth_tx -f all.f -o tb_eth_tx
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/tb_eth_tx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "SIMULATION PASSED" sim.log; then
	exit 0
fi
exit 1
